// File: logic/apb_node_pkg.sv
// APB node package
// Default widths, port count, timeout limit and shared encodings
`default_nettype none

package apb_node_pkg;

    // Number of downstream peripheral ports
    localparam int unsigned NB_MASTER_DEF = 8;

    // Upstream and downstream bus widths
    localparam int unsigned APB_ADDR_WIDTH_DEF = 32;
    localparam int unsigned APB_DATA_WIDTH_DEF = 32;

    // Access-phase cycles allowed before the guard forces completion
    localparam int unsigned RTO_CYCLES_DEF = 16;

    // Ready-timeout FSM states
    typedef enum logic [1:0] {
        RTO_IDLE  = 2'b00,
        RTO_COUNT = 2'b01,
        RTO_FIRED = 2'b10
    } rto_state_e;

    // Read data returned on a decode error or a forced completion
    localparam logic [APB_DATA_WIDTH_DEF-1:0] ERR_RDATA = 32'h0bad_0bad;

endpackage

`default_nettype wire

// File: logic/apb_if.sv
// Upstream APB bus and the node response bundle
// The response bundle carries the decoded result to the merge stage
`timescale 1ns/1ps
`default_nettype none

interface apb_if import apb_node_pkg::*; #(
    parameter int unsigned APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEF,
    parameter int unsigned APB_DATA_WIDTH = APB_DATA_WIDTH_DEF
);
    // Request
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    // Response
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

    // Observes the whole bus, final response included
    modport monitor (
        input psel, penable, pwrite, paddr, pwdata, prdata, pready, pslverr
    );
endinterface

interface apb_rsp_if import apb_node_pkg::*; #(
    parameter int unsigned NB_MASTER      = NB_MASTER_DEF,
    parameter int unsigned APB_DATA_WIDTH = APB_DATA_WIDTH_DEF
);
    logic                      node_pready;
    logic                      node_pslverr;
    logic [APB_DATA_WIDTH-1:0] node_prdata;
    // Downstream select vector, one bit per peripheral
    logic [NB_MASTER-1:0]      node_psel;

    modport src (output node_pready, node_pslverr, node_prdata, node_psel);
    modport dst (input  node_pready, node_pslverr, node_prdata, node_psel);
endinterface

`default_nettype wire

// File: logic/apb_node.sv
// APB node: address-window decode, downstream fan-out and response mux
// Purely combinational with the lowest matching window index winning
`timescale 1ns/1ps
`default_nettype none

module apb_node import apb_node_pkg::*; #(
    parameter int unsigned NB_MASTER      = NB_MASTER_DEF,
    parameter int unsigned APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEF,
    parameter int unsigned APB_DATA_WIDTH = APB_DATA_WIDTH_DEF
) (
    // Upstream request
    apb_if.slave                                          bus,
    // Decoded response towards the merge stage
    apb_rsp_if.src                                        rsp,

    // Address windows, inclusive on both ends
    input  wire logic [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] start_addr_i,
    input  wire logic [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] end_addr_i,

    // Downstream peripheral ports
    output logic      [NB_MASTER-1:0]                     penable_o,
    output logic      [NB_MASTER-1:0]                     pwrite_o,
    output logic      [NB_MASTER-1:0]                     psel_o,
    output logic      [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] paddr_o,
    output logic      [NB_MASTER-1:0][APB_DATA_WIDTH-1:0] pwdata_o,
    input  wire logic [NB_MASTER-1:0][APB_DATA_WIDTH-1:0] prdata_i,
    input  wire logic [NB_MASTER-1:0]                     pready_i,
    input  wire logic [NB_MASTER-1:0]                     pslverr_i
);

    localparam int unsigned SEL_W = (NB_MASTER > 1) ? $clog2(NB_MASTER) : 1;

    logic                 hit;
    logic [SEL_W-1:0]     sel_idx;
    logic [NB_MASTER-1:0] match;
    logic                 access;

    // Access phase of the upstream transfer
    assign access = bus.psel & bus.penable;

    // Window compare
    // Scan from the top so the lowest index is assigned last and wins
    always_comb begin
        hit     = 1'b0;
        sel_idx = '0;
        for (int i = NB_MASTER - 1; i >= 0; i--) begin
            if (bus.paddr >= start_addr_i[i] && bus.paddr <= end_addr_i[i]) begin
                hit     = 1'b1;
                sel_idx = SEL_W'(i);
            end
        end
    end

    // One-hot select that stays empty on a decode miss
    assign match = hit ? (NB_MASTER'(1) << sel_idx) : '0;

    // Request fan-out
    // Only psel is gated and the rest is broadcast to every port
    for (genvar i = 0; i < NB_MASTER; i++) begin : g_fanout
        assign psel_o[i]    = bus.psel & match[i];
        assign penable_o[i] = bus.penable;
        assign pwrite_o[i]  = bus.pwrite;
        assign paddr_o[i]   = bus.paddr;
        assign pwdata_o[i]  = bus.pwdata;
    end

    // Select vector for the sticky timeout record
    assign rsp.node_psel = psel_o;

    // Response mux
    always_comb begin
        if (hit) begin
            rsp.node_pready  = pready_i[sel_idx];
            rsp.node_pslverr = pslverr_i[sel_idx];
            rsp.node_prdata  = prdata_i[sel_idx];
        end else begin
            // Unmapped address answers at once in the access phase
            rsp.node_pready  = access;
            rsp.node_pslverr = access;
            rsp.node_prdata  = APB_DATA_WIDTH'(ERR_RDATA);
        end
    end

endmodule

`default_nettype wire

// File: logic/apb_rto_timer.sv
// Ready-timeout guard for the upstream access phase
// Pulses rto_o once when a transfer has stalled for RTO_CYCLES cycles
`timescale 1ns/1ps
`default_nettype none

module apb_rto_timer import apb_node_pkg::*; #(
    // Minimum of 2 since the pulse comes from a register
    parameter int unsigned RTO_CYCLES = RTO_CYCLES_DEF
) (
    input  wire logic clk_i,
    input  wire logic reset_i,
    apb_if.monitor    bus,
    output logic      rto_o
);

    localparam int unsigned CNT_W = (RTO_CYCLES > 2) ? $clog2(RTO_CYCLES) : 1;
    // Stalled cycles seen before the last one that still waits
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RTO_CYCLES - 2);

    rto_state_e       state_q, state_d;
    logic [CNT_W-1:0] cnt_q, cnt_d;
    logic             rto_q, rto_d;
    logic             stall;

    // Access phase with the final ready still low
    assign stall = bus.psel & bus.penable & ~bus.pready;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        rto_d   = 1'b0;
        case (state_q)
            RTO_IDLE, RTO_COUNT: begin
                if (!stall) begin
                    // No access phase, or the transfer completes now
                    state_d = RTO_IDLE;
                    cnt_d   = '0;
                end else if (cnt_q == CNT_LAST) begin
                    // Next access cycle is number RTO_CYCLES
                    state_d = RTO_FIRED;
                    cnt_d   = '0;
                    rto_d   = 1'b1;
                end else begin
                    state_d = RTO_COUNT;
                    cnt_d   = cnt_q + 1'b1;
                end
            end
            RTO_FIRED: begin
                // Hold until the forced transfer has left the access phase
                if (!(bus.psel && bus.penable)) begin
                    state_d = RTO_IDLE;
                end
            end
            default: begin
                state_d = RTO_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RTO_IDLE;
            cnt_q   <= '0;
            rto_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            rto_q   <= rto_d;
        end
    end

    // High in exactly the first FIRED cycle
    assign rto_o = rto_q;

endmodule

`default_nettype wire

// File: logic/apb_resp_merge.sv
// Upstream response merge and sticky per-peripheral timeout record
// A timeout forces completion with an error and ERR_RDATA
`timescale 1ns/1ps
`default_nettype none

module apb_resp_merge import apb_node_pkg::*; #(
    parameter int unsigned NB_MASTER      = NB_MASTER_DEF,
    parameter int unsigned APB_DATA_WIDTH = APB_DATA_WIDTH_DEF
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,

    // Decoded node response
    apb_rsp_if.dst                    rsp,

    // Timeout pulse and mask clear
    input  wire logic                 rto_i,
    input  wire logic                 rto_clear_i,

    // Final upstream response
    output logic                      pready_o,
    output logic                      pslverr_o,
    output logic [APB_DATA_WIDTH-1:0] prdata_o,

    // Peripherals that stalled since the last clear
    output logic [NB_MASTER-1:0]      peripheral_rto_o
);

    logic [NB_MASTER-1:0] mask_q;
    logic [NB_MASTER-1:0] mask_kept;
    logic [NB_MASTER-1:0] mask_set;

    // Forced completion on a timeout
    assign pready_o  = rsp.node_pready | rto_i;
    assign pslverr_o = rsp.node_pslverr | rto_i;
    assign prdata_o  = rto_i ? APB_DATA_WIDTH'(ERR_RDATA) : rsp.node_prdata;

    // Clear drops the old record
    assign mask_kept = rto_clear_i ? '0 : mask_q;

    // Peripheral selected during the timeout
    assign mask_set = rto_i ? rsp.node_psel : '0;

    // Set is OR-ed in after the clear so it wins in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q <= '0;
        end else begin
            mask_q <= mask_kept | mask_set;
        end
    end

    // Visible one cycle after the timeout edge
    assign peripheral_rto_o = mask_q;

endmodule

`default_nettype wire

// File: logic/apb_node_top.sv
// APB peripheral node with ready-timeout guard, top level
// Connects the decoder, the timeout timer and the response merge
`timescale 1ns/1ps
`default_nettype none

module apb_node_top import apb_node_pkg::*; #(
    parameter int unsigned NB_MASTER      = NB_MASTER_DEF,
    parameter int unsigned APB_ADDR_WIDTH = APB_ADDR_WIDTH_DEF,
    parameter int unsigned APB_DATA_WIDTH = APB_DATA_WIDTH_DEF,
    parameter int unsigned RTO_CYCLES     = RTO_CYCLES_DEF
) (
    input  wire logic                                     clk_i,
    input  wire logic                                     reset_i,

    // Upstream APB port
    input  wire logic                                     psel_i,
    input  wire logic                                     penable_i,
    input  wire logic                                     pwrite_i,
    input  wire logic [APB_ADDR_WIDTH-1:0]                paddr_i,
    input  wire logic [APB_DATA_WIDTH-1:0]                pwdata_i,
    output logic      [APB_DATA_WIDTH-1:0]                prdata_o,
    output logic                                          pready_o,
    output logic                                          pslverr_o,

    // Downstream peripheral ports
    output logic      [NB_MASTER-1:0]                     penable_o,
    output logic      [NB_MASTER-1:0]                     pwrite_o,
    output logic      [NB_MASTER-1:0]                     psel_o,
    output logic      [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] paddr_o,
    output logic      [NB_MASTER-1:0][APB_DATA_WIDTH-1:0] pwdata_o,
    input  wire logic [NB_MASTER-1:0][APB_DATA_WIDTH-1:0] prdata_i,
    input  wire logic [NB_MASTER-1:0]                     pready_i,
    input  wire logic [NB_MASTER-1:0]                     pslverr_i,

    // Address windows
    input  wire logic [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] start_addr_i,
    input  wire logic [NB_MASTER-1:0][APB_ADDR_WIDTH-1:0] end_addr_i,

    // Timeout record
    input  wire logic                                     rto_clear_i,
    output logic      [NB_MASTER-1:0]                     peripheral_rto_o
);

    logic rto;

    apb_if #(
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH),
        .APB_DATA_WIDTH (APB_DATA_WIDTH)
    ) i_apb ();

    apb_rsp_if #(
        .NB_MASTER      (NB_MASTER),
        .APB_DATA_WIDTH (APB_DATA_WIDTH)
    ) i_rsp ();

    // Upstream request onto the bus
    assign i_apb.psel    = psel_i;
    assign i_apb.penable = penable_i;
    assign i_apb.pwrite  = pwrite_i;
    assign i_apb.paddr   = paddr_i;
    assign i_apb.pwdata  = pwdata_i;

    // Final merged response back onto the bus where the timer sees it
    assign i_apb.pready  = pready_o;
    assign i_apb.pslverr = pslverr_o;
    assign i_apb.prdata  = prdata_o;

    apb_node #(
        .NB_MASTER      (NB_MASTER),
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH),
        .APB_DATA_WIDTH (APB_DATA_WIDTH)
    ) i_node (
        .bus          (i_apb),
        .rsp          (i_rsp),
        .start_addr_i (start_addr_i),
        .end_addr_i   (end_addr_i),
        .penable_o    (penable_o),
        .pwrite_o     (pwrite_o),
        .psel_o       (psel_o),
        .paddr_o      (paddr_o),
        .pwdata_o     (pwdata_o),
        .prdata_i     (prdata_i),
        .pready_i     (pready_i),
        .pslverr_i    (pslverr_i)
    );

    apb_rto_timer #(
        .RTO_CYCLES (RTO_CYCLES)
    ) i_rto_timer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus     (i_apb),
        .rto_o   (rto)
    );

    apb_resp_merge #(
        .NB_MASTER      (NB_MASTER),
        .APB_DATA_WIDTH (APB_DATA_WIDTH)
    ) i_resp_merge (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .rsp              (i_rsp),
        .rto_i            (rto),
        .rto_clear_i      (rto_clear_i),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .prdata_o         (prdata_o),
        .peripheral_rto_o (peripheral_rto_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock with reset held high for the first few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a rising edge like any other synchronous input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/tb_apb_node.sv
// Testbench for the APB peripheral node with ready-timeout guard
// Models four peripherals and checks every upstream transfer against a reference
`timescale 1ns/1ps
`default_nettype none

module tb_apb_node import apb_node_pkg::*; ();

    localparam int NB = 4;
    localparam int AW = 32;
    localparam int DW = 32;
    localparam int RTO = 8;
    // Peripheral that never raises pready
    localparam int STALL_IDX = 3;
    localparam int N_DECODE = 6;
    localparam int N_BURST = 40;
    // Decode writes and reads, two unmapped, one stall, one slow, then the burst
    localparam int N_XFERS = 2 * N_DECODE + 4 + N_BURST;
    localparam int CYCLE_LIMIT = 40 * N_XFERS + 100;

    typedef struct packed {
        logic          hit;
        logic [1:0]    idx;
        logic          slverr;
        logic [DW-1:0] rdata;
    } expect_t;

    // One observed upstream transfer
    typedef struct packed {
        logic                  write;
        logic [AW-1:0]         addr;
        logic [DW-1:0]         wdata;
        logic [DW-1:0]         rdata;
        logic                  slverr;
        logic [7:0]            cycles;
        logic [NB-1:0]         psel_seen;
        logic [NB-1:0]         pwrite_seen;
        logic [NB-1:0][AW-1:0] paddr_seen;
        logic [NB-1:0][DW-1:0] pwdata_seen;
    } xfer_t;

    logic clk;
    logic reset;
    logic psel, penable, pwrite, rto_clear;
    logic [AW-1:0] paddr;
    logic [DW-1:0] pwdata;
    logic [DW-1:0] prdata;
    logic pready, pslverr;
    logic [NB-1:0] psel_dn, penable_dn, pwrite_dn, peripheral_rto;
    logic [NB-1:0][AW-1:0] paddr_dn, start_addr, end_addr;
    logic [NB-1:0][DW-1:0] pwdata_dn;
    wire logic [NB-1:0][DW-1:0] prdata_dn;
    wire logic [NB-1:0] pready_dn;
    wire logic [NB-1:0] pslverr_dn;

    logic [31:0] seed = 32'h4c21;
    int checks = 0;
    int errors = 0;
    int cycle_cnt = 0;
    xfer_t xfer_q[$];

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) i_clk_gen (.clk_o(clk), .reset_o(reset));

    apb_node_top #(
        .NB_MASTER  (NB),
        .RTO_CYCLES (RTO)
    ) i_dut (
        .clk_i (clk), .reset_i (reset),
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
        .paddr_i (paddr), .pwdata_i (pwdata),
        .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .penable_o (penable_dn), .pwrite_o (pwrite_dn), .psel_o (psel_dn),
        .paddr_o (paddr_dn), .pwdata_o (pwdata_dn),
        .prdata_i (prdata_dn), .pready_i (pready_dn), .pslverr_i (pslverr_dn),
        .start_addr_i (start_addr), .end_addr_i (end_addr),
        .rto_clear_i (rto_clear), .peripheral_rto_o (peripheral_rto)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random offset inside window w
    function automatic logic [AW-1:0] window_addr(input int w, input logic [31:0] r);
        return AW'(w) * AW'(32'h1000) + AW'(r[27:16]);
    endfunction

    // Expected response from the address map where window i spans i*0x1000 to i*0x1000+0xFFF
    function automatic expect_t ref_response(input logic [AW-1:0] addr);
        expect_t e;
        e.hit    = 1'b0;
        e.idx    = '0;
        e.slverr = 1'b1;
        e.rdata  = ERR_RDATA;
        if (addr < AW'(NB) * AW'(32'h1000)) begin
            e.hit = 1'b1;
            e.idx = addr[13:12];
            // The stalled peripheral ends in a forced error
            if (e.idx != STALL_IDX) begin
                e.slverr = 1'b0;
                e.rdata  = addr ^ (DW'(e.idx) << 24);
            end
        end
        return e;
    endfunction

    // Access cycle in which pready is expected
    function automatic int expected_cycles(input expect_t e);
        if (!e.hit) return 1;
        if (e.idx == STALL_IDX) return RTO;
        return e.idx + 1;
    endfunction

    task automatic check_xfer(input xfer_t x);
        expect_t e;
        logic [NB-1:0] sel_exp;
        e = ref_response(x.addr);
        sel_exp = e.hit ? (NB'(1) << e.idx) : '0;
        check_value("psel_o", x.psel_seen, sel_exp);
        check_value("pslverr_o", x.slverr, e.slverr);
        check_value("pready_o access cycle", x.cycles, expected_cycles(e));
        if (!x.write) check_value("prdata_o", x.rdata, e.rdata);
        if (e.hit) begin
            check_value("pwrite_o", x.pwrite_seen[e.idx], x.write);
            check_value("paddr_o", x.paddr_seen[e.idx], x.addr);
            check_value("pwdata_o", x.pwdata_seen[e.idx], x.wdata);
        end
    endtask

    // Setup and access phases with the response sampled on the falling edge
    task automatic do_transfer(input logic write, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata);
        xfer_t x;
        logic done;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        x = '0;
        x.write = write;
        x.addr  = addr;
        x.wdata = wdata;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            x.cycles = x.cycles + 1;
            x.psel_seen = x.psel_seen | psel_dn;
            if (x.cycles == 1) begin
                x.pwrite_seen = pwrite_dn;
                x.paddr_seen  = paddr_dn;
                x.pwdata_seen = pwdata_dn;
            end
            if (pready) begin
                done     = 1'b1;
                x.rdata  = prdata;
                x.slverr = pslverr;
            end
        end
        xfer_q.push_back(x);
    endtask

    task automatic go_idle();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic finish_test(input int num, input string name, inout int c0, inout int e0);
        while (xfer_q.size() != 0) @(posedge clk);
        @(negedge clk);
        $display("test %0d %s: %0d checks, %0d errors", num, name, checks - c0, errors - e0);
        c0 = checks;
        e0 = errors;
    endtask

    // Peripheral p holds pready low for p access cycles
    for (genvar p = 0; p < NB; p++) begin : g_periph
        int wait_cnt = 0;
        always @(posedge clk) begin
            if (reset || !(psel_dn[p] && penable_dn[p]) || pready_dn[p]) begin
                wait_cnt <= 0;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
        assign pready_dn[p]  = (p != STALL_IDX) && (wait_cnt >= p);
        assign prdata_dn[p]  = paddr_dn[p] ^ (DW'(p) << 24);
        assign pslverr_dn[p] = 1'b0;
    end

    // Compares each finished transfer with the reference
    always @(posedge clk) begin
        if (xfer_q.size() > 0) check_xfer(xfer_q.pop_front());
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, timer state %s",
                     cycle_cnt, i_dut.i_rto_timer.state_q.name());
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int c0;
        int e0;
        logic [NB-1:0] mask_before;
        c0 = 0;
        e0 = 0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rto_clear = 1'b0;
        for (int i = 0; i < NB; i++) begin
            start_addr[i] = AW'(i) * AW'(32'h1000);
            end_addr[i]   = AW'(i) * AW'(32'h1000) + AW'(32'hfff);
        end
        while (reset !== 1'b0) @(posedge clk);
        @(negedge clk);
        check_value("peripheral_rto_o", peripheral_rto, '0);

        for (int n = 0; n < N_DECODE; n++) begin
            seed = lcg_next(seed);
            do_transfer(1'b1, window_addr(n % 3, seed), lcg_next(seed));
        end
        go_idle();
        finish_test(1, "write decode", c0, e0);

        for (int n = 0; n < N_DECODE; n++) begin
            seed = lcg_next(seed);
            do_transfer(1'b0, window_addr(n % 3, seed), '0);
        end
        go_idle();
        finish_test(2, "read data", c0, e0);

        // Unmapped addresses above 0x3fff
        mask_before = peripheral_rto;
        seed = lcg_next(seed);
        do_transfer(1'b0, 32'h0000_4000 + {16'h0, seed[31:16]}, '0);
        do_transfer(1'b0, seed | 32'h8000_0000, '0);
        go_idle();
        @(negedge clk);
        check_value("peripheral_rto_o", peripheral_rto, mask_before);
        finish_test(3, "decode error", c0, e0);

        // Stalled peripheral whose mask bit appears one cycle after completion
        do_transfer(1'b0, window_addr(STALL_IDX, seed), '0);
        check_value("peripheral_rto_o[3]", peripheral_rto[3], 1'b0);
        go_idle();
        @(negedge clk);
        check_value("peripheral_rto_o[3]", peripheral_rto[3], 1'b1);
        finish_test(4, "ready timeout", c0, e0);

        @(posedge clk);
        rto_clear <= 1'b1;
        @(posedge clk);
        rto_clear <= 1'b0;
        @(negedge clk);
        check_value("peripheral_rto_o", peripheral_rto, '0);
        do_transfer(1'b0, window_addr(2, lcg_next(seed)), '0);
        go_idle();
        @(negedge clk);
        check_value("peripheral_rto_o", peripheral_rto, '0);
        finish_test(5, "mask clear", c0, e0);

        // Back-to-back burst where about one in five lands above the mapped windows
        for (int n = 0; n < N_BURST; n++) begin
            seed = lcg_next(seed);
            do_transfer(seed[31], {16'h0, seed[23:8]} % AW'(32'h5000), lcg_next(seed));
        end
        go_idle();
        finish_test(6, "random burst", c0, e0);

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/apb_node_pkg.sv
logic/apb_if.sv
logic/apb_node.sv
logic/apb_rto_timer.sv
logic/apb_resp_merge.sv
logic/apb_node_top.sv
sim/tb_clk_gen.sv
sim/tb_apb_node.sv

// File: Bender.yml
package:
  name: apb_node

sources:
  - logic/apb_node_pkg.sv
  - logic/apb_if.sv
  - logic/apb_node.sv
  - logic/apb_rto_timer.sv
  - logic/apb_resp_merge.sv
  - logic/apb_node_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_apb_node.sv
